/* flist.f */
+incdir+common
common/mips_pkg.sv
hw/core/program_counter.sv
hw/core/control_unit.sv
hw/core/register_file.sv
hw/core/alu.sv
hw/core/execute_stage.sv
hw/core/mips_core.sv
dv/tb_mips_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_mips_core
FLIST     := flist.f
MDIR      := obj_dir
LINTFLAGS := --lint-only --timing
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(MDIR)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(MDIR)

/* dv/tb_mips_core.sv */
/* runs a fixed program under random ihit and checks every retire against an ISA model
   program must end in halt; fetches stay inside the 256-word instruction memory */

`include "mips_cfg.svh"

module tb_mips_core;
   timeunit 1ns;
   timeprecision 100ps;
   import mips_pkg::*;

   // MIPS opcode and funct field values
   localparam int op_rtype = 0;
   localparam int op_j     = 2;
   localparam int op_beq   = 4;
   localparam int op_bne   = 5;
   localparam int op_addiu = 9;
   localparam int op_slti  = 10;
   localparam int op_sltiu = 11;
   localparam int op_andi  = 12;
   localparam int op_ori   = 13;
   localparam int op_xori  = 14;
   localparam int op_lui   = 15;
   localparam int op_halt  = int'(`MIPS_OP_HALT);
   localparam int fn_sll   = 0;
   localparam int fn_srl   = 2;
   localparam int fn_addu  = 33;
   localparam int fn_subu  = 35;
   localparam int fn_and   = 36;
   localparam int fn_or    = 37;
   localparam int fn_xor   = 38;
   localparam int fn_nor   = 39;
   localparam int fn_slt   = 42;
   localparam int fn_sltu  = 43;

   logic     CLK;
   logic     nRST;
   logic     ihit;
   word_t    imem_addr;
   word_t    imem_data;
   retire_t  retire;
   logic     halted;

   word_t    imem [256];
   retire_t  exp_q [$];     // expected writes, program order
   retire_t  exp_w;
   integer   seed;
   int       mismatch_errs;
   int       protocol_errs;
   int       timeout_errs;
   logic     stall_prev;    // ihit low going into the last edge
   word_t    addr_prev;
   logic     halt_seen;

   mips_core mips_core_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .ihit      (ihit),
      .retire    (retire),
      .halted    (halted)
   );

   always #50 CLK = ~CLK;

   assign imem_data = imem[imem_addr[9:2]];  // combinational read

   always @(posedge CLK) begin
      ihit <= (($unsigned($random(seed)) % 10) < 7);  // ~70 % hit
   end

   // **************************************************
   // instruction encoders
   // **************************************************
   function automatic word_t rtype_word(int fn, int rd, int rs, int rt, int sh);
      return {6'b000000, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn[5:0]};
   endfunction

   function automatic word_t itype_word(int op, int rt, int rs, int imm);
      return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   function automatic word_t jump_word(int idx);
      return {6'b000010, idx[25:0]};
   endfunction

   task automatic load_program();
      for (int i = 0; i < 256; i++) begin
         imem[i] = {`MIPS_OP_HALT, 18'b0, i[7:0]};  // stray fetch halts
      end
      imem[0]  = itype_word(op_addiu, 1, 0, 'h1234);
      imem[1]  = itype_word(op_addiu, 2, 0, -3);          // sign extended
      imem[2]  = rtype_word(fn_addu, 3, 1, 2, 0);         // dist 1 and 2
      imem[3]  = rtype_word(fn_subu, 4, 3, 1, 0);
      imem[4]  = rtype_word(fn_and, 5, 4, 1, 0);
      imem[5]  = rtype_word(fn_or, 6, 5, 2, 0);
      imem[6]  = rtype_word(fn_xor, 7, 6, 3, 0);
      imem[7]  = rtype_word(fn_nor, 8, 7, 0, 0);
      imem[8]  = rtype_word(fn_slt, 9, 2, 1, 0);
      imem[9]  = rtype_word(fn_sltu, 10, 2, 1, 0);
      imem[10] = rtype_word(fn_sll, 11, 0, 1, 4);
      imem[11] = rtype_word(fn_srl, 12, 0, 2, 28);
      imem[12] = rtype_word(fn_addu, 0, 1, 1, 0);         // $0 dest, no retire
      imem[13] = rtype_word(fn_addu, 13, 0, 1, 0);        // $0 must not forward
      imem[14] = itype_word(op_andi, 14, 2, 'hff00);      // zero extended
      imem[15] = itype_word(op_ori, 15, 0, 'h8001);
      imem[16] = itype_word(op_xori, 16, 15, 'hffff);
      imem[17] = itype_word(op_slti, 17, 2, -2);
      imem[18] = itype_word(op_sltiu, 18, 1, -1);
      imem[19] = itype_word(op_lui, 19, 0, 'habcd);
      imem[20] = itype_word(op_ori, 19, 19, 'h5678);
      imem[21] = itype_word(op_beq, 2, 1, 5);             // not taken
      imem[22] = itype_word(op_bne, 13, 1, 5);            // not taken
      imem[23] = itype_word(op_beq, 1, 13, 2);            // taken to 26
      imem[24] = itype_word(op_addiu, 20, 0, 1);
      imem[25] = itype_word(op_addiu, 21, 0, 2);
      imem[26] = itype_word(op_bne, 2, 1, 2);             // taken to 29
      imem[27] = itype_word(op_addiu, 20, 0, 3);
      imem[28] = itype_word(op_addiu, 21, 0, 4);
      imem[29] = jump_word(33);
      imem[30] = itype_word(op_addiu, 20, 0, 5);
      imem[31] = itype_word(op_addiu, 21, 0, 6);
      imem[32] = itype_word(op_addiu, 20, 0, 7);
      imem[33] = itype_word(op_addiu, 22, 19, 1);
      imem[34] = rtype_word(fn_sll, 0, 0, 0, 0);          // nop
      imem[35] = rtype_word(fn_subu, 23, 22, 19, 0);      // via regfile bypass
      imem[36] = itype_word(op_addiu, 24, 0, 3);          // loop count
      imem[37] = itype_word(op_addiu, 25, 25, 5);
      imem[38] = itype_word(op_addiu, 24, 24, -1);
      imem[39] = itype_word(op_bne, 0, 24, -3);           // back to 37
      imem[40] = {`MIPS_OP_HALT, 26'b0};
      imem[41] = itype_word(op_addiu, 26, 0, 9);          // never retires
   endtask

   // **************************************************
   // ISA model, program order, no delay slots
   // **************************************************
   task automatic run_model();
      word_t      r [32];
      word_t      pc;
      word_t      pc4;
      word_t      w;
      word_t      res;
      word_t      sx;
      word_t      zx;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] dst;
      logic       wr;
      logic       done;
      retire_t    ent;
      int         steps;
      for (int i = 0; i < 32; i++) begin
         r[i] = '0;
      end
      pc    = `MIPS_PC_INIT;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         w   = imem[pc[9:2]];
         pc4 = pc + 32'd4;
         pc  = pc4;
         rs  = w[25:21];
         rt  = w[20:16];
         sx  = {{16{w[15]}}, w[15:0]};
         zx  = {16'b0, w[15:0]};
         dst = rt;
         res = '0;
         wr  = 1'b1;
         case (int'(w[31:26]))
            op_rtype: begin
               dst = w[15:11];
               case (int'(w[5:0]))
                  fn_sll:  res = r[rt] << w[10:6];
                  fn_srl:  res = r[rt] >> w[10:6];
                  fn_addu: res = r[rs] + r[rt];
                  fn_subu: res = r[rs] - r[rt];
                  fn_and:  res = r[rs] & r[rt];
                  fn_or:   res = r[rs] | r[rt];
                  fn_xor:  res = r[rs] ^ r[rt];
                  fn_nor:  res = ~(r[rs] | r[rt]);
                  fn_slt:  res = {31'b0, ($signed(r[rs]) < $signed(r[rt]))};
                  fn_sltu: res = {31'b0, (r[rs] < r[rt])};
                  default: wr = 1'b0;
               endcase
            end
            op_j: begin
               wr = 1'b0;
               pc = {pc4[31:28], w[25:0], 2'b00};
            end
            op_beq: begin
               wr = 1'b0;
               if (r[rs] == r[rt]) pc = pc4 + {sx[29:0], 2'b00};
            end
            op_bne: begin
               wr = 1'b0;
               if (r[rs] != r[rt]) pc = pc4 + {sx[29:0], 2'b00};
            end
            op_addiu: res = r[rs] + sx;
            op_slti:  res = {31'b0, ($signed(r[rs]) < $signed(sx))};
            op_sltiu: res = {31'b0, (r[rs] < sx)};       // unsigned vs sign-ext imm
            op_andi:  res = r[rs] & zx;
            op_ori:   res = r[rs] | zx;
            op_xori:  res = r[rs] ^ zx;
            op_lui:   res = {w[15:0], 16'b0};
            op_halt: begin
               wr   = 1'b0;
               done = 1'b1;
            end
            default: wr = 1'b0;
         endcase
         if (wr && (dst != 5'd0)) begin
            r[dst]    = res;
            ent.valid = 1'b1;
            ent.dest  = dst;
            ent.data  = res;
            exp_q.push_back(ent);
         end
         steps++;
      end
   endtask

   task automatic report_value(string name, word_t got, word_t exp);
      $display("ERROR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      mismatch_errs++;
   endtask

   // **************************************************
   // checks, sampled mid-cycle
   // **************************************************
   always @(negedge CLK) begin
      if (nRST) begin
         if (retire.valid) begin
            if (exp_q.size() == 0) begin
               $display("t=%0t retire pulse with no write left in the model", $time);
               protocol_errs++;
            end else begin
               exp_w = exp_q.pop_front();
               assert (retire.dest == exp_w.dest)
                  else report_value("retire.dest", 32'(retire.dest), 32'(exp_w.dest));
               assert (retire.data == exp_w.data)
                  else report_value("retire.data", retire.data, exp_w.data);
            end
         end
         if (stall_prev) begin
            assert (imem_addr == addr_prev)
               else report_value("imem_addr", imem_addr, addr_prev);
            assert (!retire.valid) else begin
               $display("t=%0t retire pulse after a cycle with ihit low", $time);
               protocol_errs++;
            end
         end
         if (halt_seen) begin
            assert (halted) else begin
               $display("t=%0t halted dropped before reset", $time);
               protocol_errs++;
            end
            assert (!retire.valid) else begin
               $display("t=%0t retire pulse after the core halted", $time);
               protocol_errs++;
            end
         end
         stall_prev = !ihit;  // value the next edge samples
         addr_prev  = imem_addr;
         if (halted) halt_seen = 1'b1;
      end
   end

   initial begin
      int cyc;
      CLK           = 1'b0;
      nRST          = 1'b0;
      ihit          = 1'b0;
      seed          = 8;
      mismatch_errs = 0;
      protocol_errs = 0;
      timeout_errs  = 0;
      stall_prev    = 1'b0;
      addr_prev     = '0;
      halt_seen     = 1'b0;
      load_program();
      run_model();
      repeat (4) @(posedge CLK);
      nRST <= 1'b1;
      for (cyc = 0; (cyc < 2000) && !halted; cyc++) begin
         @(negedge CLK);
      end
      if (!halted) begin
         $display("timeout, halted did not rise within 2000 cycles");
         timeout_errs++;
      end else begin
         repeat (20) @(posedge CLK);  // window for stray retires
      end
      if (exp_q.size() != 0) begin
         $display("%0d expected register writes never retired", exp_q.size());
         protocol_errs++;
      end
      $display("errors: mismatch=%0d protocol=%0d timeout=%0d",
               mismatch_errs, protocol_errs, timeout_errs);
      if ((mismatch_errs + protocol_errs + timeout_errs) == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* hw/core/mips_core.sv */
/* fetch/decode/execute/writeback core, stalls on ihit low only
   no loads, stores, jal or jr; branches resolve in execute with no delay slot */

module mips_core (
   input  logic              CLK,
   input  logic              nRST,
   output mips_pkg::word_t   imem_addr,
   input  mips_pkg::word_t   imem_data,
   input  logic              ihit,
   output mips_pkg::retire_t retire,
   output logic              halted
);
   import mips_pkg::*;

   word_t    pc;
   word_t    pc_plus_4;
   word_t    target;
   word_t    if_instr;       // IF/ID latch
   word_t    if_pc_plus_4;
   logic     if_valid;
   logic     advance;
   logic     redirect;
   logic     halt_hit;
   ctrl_t    ctrl;
   regbits_t rs;
   regbits_t rt;
   regbits_t dest;
   word_t    rdat1;
   word_t    rdat2;
   id_ex_t   id_in;
   ex_wb_t   ex_wb;

   // **************************************************
   // pipeline advance
   // **************************************************
   assign halt_hit = ex_wb.valid & ex_wb.halt;      // halt sitting in writeback
   assign advance  = ihit & ~halted & ~halt_hit;    // halt_hit stops the next shift at once

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         halted <= 1'b0;
      end else if (halt_hit) begin
         halted <= 1'b1;  // sticky until reset
      end
   end

   // **************************************************
   // fetch
   // **************************************************
   program_counter pc_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .advance   (advance),
      .redirect  (redirect),
      .target    (target),
      .pc        (pc),
      .pc_plus_4 (pc_plus_4)
   );

   assign imem_addr = pc;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         if_valid     <= 1'b0;
         if_instr     <= '0;
         if_pc_plus_4 <= '0;
      end else if (advance) begin
         if (redirect) begin
            if_valid <= 1'b0;  // wrong-path fetch dropped
         end else begin
            if_valid     <= 1'b1;
            if_instr     <= imem_data;
            if_pc_plus_4 <= pc_plus_4;
         end
      end
   end

   // **************************************************
   // decode
   // **************************************************
   control_unit cu_i (
      .instr (if_instr),
      .ctrl  (ctrl),
      .rs    (rs),
      .rt    (rt),
      .dest  (dest)
   );

   // writeback port driven straight from the EX/WB latch
   register_file rf_i (
      .CLK   (CLK),
      .nRST  (nRST),
      .wen   (ex_wb.valid & ex_wb.reg_write),
      .wsel  (ex_wb.dest),
      .wdat  (ex_wb.result),
      .rsel1 (rs),
      .rsel2 (rt),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   always_comb begin
      id_in.valid     = if_valid;
      id_in.ctrl      = ctrl;
      id_in.rs        = rs;
      id_in.rt        = rt;
      id_in.dest      = dest;
      id_in.rs_data   = rdat1;
      id_in.rt_data   = rdat2;
      id_in.imm16     = if_instr[15:0];
      id_in.shamt     = if_instr[10:6];
      id_in.jidx      = if_instr[25:0];
      id_in.pc_plus_4 = if_pc_plus_4;
   end

   // **************************************************
   // execute and writeback
   // **************************************************
   execute_stage ex_i (
      .CLK      (CLK),
      .nRST     (nRST),
      .advance  (advance),
      .flush    (redirect),    // own redirect also bubbles ID/EX
      .id_in    (id_in),
      .ex_wb    (ex_wb),
      .retire   (retire),
      .redirect (redirect),
      .target   (target)
   );

endmodule

/* hw/core/execute_stage.sv */
/* ID/EX and EX/WB latches, forwarding from EX/WB only, branch resolve
   a redirect bubbles ID/EX on the same advance that moves the branch on */

module execute_stage (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              advance,
   input  logic              flush,
   input  mips_pkg::id_ex_t  id_in,
   output mips_pkg::ex_wb_t  ex_wb,
   output mips_pkg::retire_t retire,
   output logic              redirect,
   output mips_pkg::word_t   target
);
   import mips_pkg::*;

   id_ex_t id_ex;
   ex_wb_t wb_next;
   logic   retire_pulse;
   logic   fwd_a;
   logic   fwd_b;
   word_t  rs_val;
   word_t  rt_val;
   word_t  ext_imm;
   word_t  alu_a;
   word_t  alu_b;
   word_t  alu_out;
   logic   alu_zero;
   logic   taken;

   // **************************************************
   // latches
   // **************************************************
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         id_ex        <= '0;
         ex_wb        <= '0;
         retire_pulse <= 1'b0;
      end else if (advance) begin
         if (flush) begin
            id_ex <= '0;  // bubble
         end else begin
            id_ex <= id_in;
         end
         ex_wb        <= wb_next;
         retire_pulse <= wb_next.reg_write;  // one cycle per retired write
      end else begin
         retire_pulse <= 1'b0;
      end
   end

   // **************************************************
   // operands
   // **************************************************
   assign fwd_a = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest != '0) &&
                  (ex_wb.dest == id_ex.rs);
   assign fwd_b = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest != '0) &&
                  (ex_wb.dest == id_ex.rt);
   assign rs_val = fwd_a ? ex_wb.result : id_ex.rs_data;
   assign rt_val = fwd_b ? ex_wb.result : id_ex.rt_data;

   assign ext_imm = id_ex.ctrl.sign_ext ? {{16{id_ex.imm16[15]}}, id_ex.imm16}
                                        : {16'b0, id_ex.imm16};
   assign alu_a   = id_ex.ctrl.shift_src ? rt_val : rs_val;  // sll/srl shift rt

   always_comb begin
      if (id_ex.ctrl.shift_src) begin
         alu_b = word_t'(id_ex.shamt);
      end else if (id_ex.ctrl.alu_src_imm) begin
         alu_b = ext_imm;
      end else begin
         alu_b = rt_val;
      end
   end

   alu alu_i (
      .op     (id_ex.ctrl.alu_op),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_out),
      .zero   (alu_zero)
   );

   // **************************************************
   // branch / jump
   // **************************************************
   assign taken    = (id_ex.ctrl.beq & alu_zero) | (id_ex.ctrl.bne & ~alu_zero);
   assign redirect = id_ex.valid & (id_ex.ctrl.jump | taken);
   assign target   = id_ex.ctrl.jump ? {id_ex.pc_plus_4[31:28], id_ex.jidx, 2'b00}
                   : id_ex.pc_plus_4 + {{14{id_ex.imm16[15]}}, id_ex.imm16, 2'b00};

   always_comb begin
      wb_next.valid     = id_ex.valid;
      wb_next.reg_write = id_ex.valid & id_ex.ctrl.reg_write & (id_ex.dest != '0);
      wb_next.dest      = id_ex.dest;
      wb_next.result    = id_ex.ctrl.lui ? {id_ex.imm16, 16'b0} : alu_out;
      wb_next.halt      = id_ex.valid & id_ex.ctrl.halt;
   end

   assign retire.valid = retire_pulse;
   assign retire.dest  = ex_wb.dest;
   assign retire.data  = ex_wb.result;

endmodule

/* hw/core/alu.sv */
/* combinational integer ALU, no overflow detection
   shifts take the amount from b[4:0] and shift a */

module alu (
   input  mips_pkg::aluop_t op,
   input  mips_pkg::word_t  a,
   input  mips_pkg::word_t  b,
   output mips_pkg::word_t  result,
   output logic             zero
);
   import mips_pkg::*;

   always_comb begin
      case (op)
         ALU_SLL:  result = a << b[4:0];
         ALU_SRL:  result = a >> b[4:0];   // logical
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLT:  result = word_t'($signed(a) < $signed(b));
         ALU_SLTU: result = word_t'(a < b);
         default:  result = '0;
      endcase
   end

   // beq/bne compare through subtract
   assign zero = (result == '0);

endmodule

/* hw/core/register_file.sv */
/* 32x32 registers, one write and two read ports, $0 always reads zero
   a read of the register being written returns the write data */

`include "mips_cfg.svh"

module register_file (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               wen,
   input  mips_pkg::regbits_t wsel,
   input  mips_pkg::word_t    wdat,
   input  mips_pkg::regbits_t rsel1,
   input  mips_pkg::regbits_t rsel2,
   output mips_pkg::word_t    rdat1,
   output mips_pkg::word_t    rdat2
);
   import mips_pkg::*;

   word_t regs [`MIPS_NREGS];  // entry 0 never written

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `MIPS_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   // bypass so decode sees the value writeback is storing this cycle
   assign rdat1 = (rsel1 == '0)             ? '0   :
                  (wen && (wsel == rsel1))  ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == '0)             ? '0   :
                  (wen && (wsel == rsel2))  ? wdat : regs[rsel2];

endmodule

/* hw/core/control_unit.sv */
/* combinational decode of the IF/ID word
   unknown opcodes and functs come out as a nop with no register write */

module control_unit (
   input  mips_pkg::word_t    instr,
   output mips_pkg::ctrl_t    ctrl,
   output mips_pkg::regbits_t rs,
   output mips_pkg::regbits_t rt,
   output mips_pkg::regbits_t dest
);
   import mips_pkg::*;

   opcode_t op;
   funct_t  fn;

   assign op   = opcode_t'(instr[31:26]);
   assign fn   = funct_t'(instr[5:0]);
   assign rs   = instr[25:21];
   assign rt   = instr[20:16];
   assign dest = ctrl.reg_dst_rd ? instr[15:11] : rt;  // rd for R-type

   always_comb begin
      ctrl = '0;
      case (op)
         RTYPE: begin
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_write  = 1'b1;
            case (fn)
               SLL: begin
                  ctrl.alu_op    = ALU_SLL;
                  ctrl.shift_src = 1'b1;
               end
               SRL: begin
                  ctrl.alu_op    = ALU_SRL;
                  ctrl.shift_src = 1'b1;
               end
               ADDU:    ctrl.alu_op = ALU_ADD;
               SUBU:    ctrl.alu_op = ALU_SUB;
               AND:     ctrl.alu_op = ALU_AND;
               OR:      ctrl.alu_op = ALU_OR;
               XOR:     ctrl.alu_op = ALU_XOR;
               NOR:     ctrl.alu_op = ALU_NOR;
               SLT:     ctrl.alu_op = ALU_SLT;
               SLTU:    ctrl.alu_op = ALU_SLTU;
               default: ctrl.reg_write = 1'b0;  // unsupported funct
            endcase
         end
         J:   ctrl.jump = 1'b1;
         BEQ: begin
            ctrl.alu_op = ALU_SUB;  // zero flag decides
            ctrl.beq    = 1'b1;
         end
         BNE: begin
            ctrl.alu_op = ALU_SUB;
            ctrl.bne    = 1'b1;
         end
         ADDIU, SLTI, SLTIU: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;   // sltiu sign-extends too, compare unsigned
            ctrl.reg_write   = 1'b1;
            ctrl.alu_op      = (op == ADDIU) ? ALU_ADD : (op == SLTI) ? ALU_SLT : ALU_SLTU;
         end
         ANDI, ORI, XORI: begin
            ctrl.alu_src_imm = 1'b1;   // zero extended
            ctrl.reg_write   = 1'b1;
            ctrl.alu_op      = (op == ANDI) ? ALU_AND : (op == ORI) ? ALU_OR : ALU_XOR;
         end
         LUI: begin
            ctrl.lui       = 1'b1;     // result replaced in execute
            ctrl.reg_write = 1'b1;
         end
         HALT:    ctrl.halt = 1'b1;
         default: ctrl = '0;
      endcase
   end

endmodule

/* hw/core/program_counter.sv */
/* fetch address register, moves only when the pipeline advances
   redirect wins over the sequential +4 */

`include "mips_cfg.svh"

module program_counter (
   input  logic            CLK,
   input  logic            nRST,
   input  logic            advance,
   input  logic            redirect,
   input  mips_pkg::word_t target,
   output mips_pkg::word_t pc,
   output mips_pkg::word_t pc_plus_4
);
   import mips_pkg::*;

   word_t pc_next;

   assign pc_plus_4 = pc + word_t'(4);
   assign pc_next   = redirect ? target : pc_plus_4;  // taken branch or j

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc <= `MIPS_PC_INIT;
      end else if (advance) begin
         pc <= pc_next;  // held while ihit low or halted
      end
   end

endmodule

/* common/mips_pkg.sv */
/* types for the four-stage core: opcode/funct/alu enums and latch structs
   only the integer subset listed in the enums is decoded, the rest is a nop */

`include "mips_cfg.svh"

package mips_pkg;

   typedef logic [`MIPS_WORD_W-1:0] word_t;
   typedef logic [`MIPS_REG_AW-1:0] regbits_t;

   // **************************************************
   // instruction fields
   // **************************************************
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      SLTIU = 6'b001011,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      HALT  = `MIPS_OP_HALT
   } opcode_t;

   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
      ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
   } aluop_t;

   // **************************************************
   // pipeline latches
   // **************************************************
   typedef struct packed {
      aluop_t alu_op;
      logic   alu_src_imm;  // b from immediate
      logic   shift_src;    // shamt on b, rt on a
      logic   sign_ext;
      logic   reg_dst_rd;   // dest is rd, else rt
      logic   reg_write;
      logic   lui;
      logic   beq;
      logic   bne;
      logic   jump;
      logic   halt;
   } ctrl_t;

   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      regbits_t    rs;
      regbits_t    rt;
      regbits_t    dest;
      word_t       rs_data;
      word_t       rt_data;
      logic [15:0] imm16;
      regbits_t    shamt;
      logic [25:0] jidx;      // j target index
      word_t       pc_plus_4;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      logic     reg_write;    // already cleared for $0
      regbits_t dest;
      word_t    result;
      logic     halt;
   } ex_wb_t;

   // one retired register write
   typedef struct packed {
      logic     valid;
      regbits_t dest;
      word_t    data;
   } retire_t;

endpackage

/* common/mips_cfg.svh */
/* core-wide widths and special encodings, shared by the RTL and the testbench
   branch and jump target math assumes a 32-bit word */

`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// **************************************************
// datapath widths
// **************************************************
`define MIPS_WORD_W  32          // data and address width
`define MIPS_REG_AW  5           // register select width
`define MIPS_NREGS   32          // architectural registers, $0 included

// **************************************************
// reset and special encodings
// **************************************************
`define MIPS_PC_INIT 32'h0000_0000 // first fetch address out of reset

// not a MIPS opcode, freezes the core once it reaches writeback
`define MIPS_OP_HALT 6'b111111

`endif
